//--- rtl/hart_pkg.sv
package hart_pkg;

  // one 32-bit data, address or instruction word
  typedef logic [31:0] word_t;

  // architectural register index, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // operations the execute ALU knows about
  // pass-b forwards operand b unchanged, which is all lui needs
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // fetch controller states
  // REQUEST is the normal state, with the bus either idle or in a read
  // DISCARD waits out a read whose data a taken branch has made stale
  // HALTED is entered on ebreak and left only through reset
  typedef enum logic [1:0] {
    REQUEST,
    DISCARD,
    HALTED
  } fetch_state_e;

  // first fetch address after reset
  localparam word_t RESET_ADDR = 32'h0000_0000;

  // major opcodes of the supported instruction groups
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ebreak is the only SYSTEM encoding the hart acts on
  localparam word_t EBREAK_INST = 32'h0010_0073;

  // addi x0, x0, 0, which is what a bubble or an unknown word decodes to
  localparam word_t NOP_INST = 32'h0000_0013;

endpackage

//--- rtl/exec_bus_if.sv
`timescale 1ns/1ps

// one decoded instruction, as held in the decode/execute register
interface exec_bus_if import hart_pkg::*; ();

  logic      valid;
  word_t     pc;
  // the raw fetched word, kept for retire and ebreak detection
  word_t     inst;
  alu_op_e   alu_op;
  logic      operand_b_is_imm;
  word_t     imm;
  // source indices are 0 when the instruction does not read that port
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd_addr;
  logic      rd_we;
  logic      is_branch;
  // selects bne over beq
  logic      branch_ne;

  modport decode_mp (
    output valid, pc, inst, alu_op, operand_b_is_imm, imm, rs1_addr, rs2_addr,
           rs1_data, rs2_data, rd_addr, rd_we, is_branch, branch_ne
  );

  modport execute_mp (
    input valid, pc, inst, alu_op, operand_b_is_imm, imm, rs1_addr, rs2_addr,
          rs1_data, rs2_data, rd_addr, rd_we, is_branch, branch_ne
  );

endinterface

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import hart_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  word_t i_imem_dat,
  input  logic  i_imem_ack,
  input  logic  i_redirect,
  input  word_t i_redirect_pc,
  input  logic  i_halt_seen,
  output logic  o_imem_cyc,
  output logic  o_imem_stb,
  output word_t o_imem_adr,
  output logic  o_valid,
  output word_t o_pc,
  output word_t o_inst
);

  fetch_state_e state_q;
  // high while a Wishbone read is on the bus
  logic         req_q;
  // address of the next instruction to request
  word_t        pc_q;
  // address of the read in flight, held stable while cyc is high
  word_t        adr_q;
  logic         fd_valid_q;
  word_t        fd_pc_q;
  word_t        fd_inst_q;

  // cyc and stb always move together since there is a single slave
  assign o_imem_cyc = req_q;
  assign o_imem_stb = req_q;
  assign o_imem_adr = adr_q;

  assign o_valid = fd_valid_q;
  assign o_pc    = fd_pc_q;
  assign o_inst  = fd_inst_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= REQUEST;
      req_q      <= 1'b0;
      pc_q       <= RESET_ADDR;
      fd_valid_q <= 1'b0;
    end else begin
      // the fetch/decode register holds a bubble unless a read is accepted
      fd_valid_q <= 1'b0;
      case (state_q)
        REQUEST: begin
          if (i_redirect) begin
            pc_q <= i_redirect_pc;
            // a read still waiting for ack has to run to its end first
            if (req_q && !i_imem_ack) begin
              state_q <= DISCARD;
            end else begin
              // an ack on this edge brings a wrong-path word, so drop it
              req_q <= 1'b0;
            end
          end else if (req_q) begin
            if (i_imem_ack) begin
              req_q      <= 1'b0;
              pc_q       <= pc_q + 32'd4;
              fd_valid_q <= 1'b1;
              fd_pc_q    <= adr_q;
              fd_inst_q  <= i_imem_dat;
            end
          end else if (i_halt_seen) begin
            // decode only sees a word in the idle cycle after its ack,
            // so no read is outstanding when the halt is taken
            state_q <= HALTED;
          end else begin
            // the idle cycle has passed, start the next read
            req_q <= 1'b1;
            adr_q <= pc_q;
          end
        end
        DISCARD: begin
          if (i_redirect) begin
            pc_q <= i_redirect_pc;
          end
          if (i_imem_ack) begin
            req_q   <= 1'b0;
            state_q <= REQUEST;
          end
        end
        HALTED: begin
          req_q <= 1'b0;
        end
        default: begin
          state_q <= REQUEST;
          req_q   <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  input  logic      i_wb_we,
  input  reg_addr_t i_wb_addr,
  input  word_t     i_wb_data,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  // x0 has no storage and is produced by the read muxes
  word_t regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_we && (i_wb_addr != '0)) begin
      regs[i_wb_addr] <= i_wb_data;
    end
  end

  // a read of the register being written this cycle sees the new value,
  // which covers the instruction two places ahead of the reader
  always_comb begin
    if (i_rs1_addr == '0) begin
      o_rs1_data = '0;
    end else if (i_wb_we && (i_wb_addr == i_rs1_addr)) begin
      o_rs1_data = i_wb_data;
    end else begin
      o_rs1_data = regs[i_rs1_addr];
    end
    if (i_rs2_addr == '0) begin
      o_rs2_data = '0;
    end else if (i_wb_we && (i_wb_addr == i_rs2_addr)) begin
      o_rs2_data = i_wb_data;
    end else begin
      o_rs2_data = regs[i_rs2_addr];
    end
  end

endmodule

//--- rtl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_valid,
  input  word_t     i_pc,
  input  word_t     i_inst,
  input  logic      i_redirect,
  input  logic      i_wb_we,
  input  reg_addr_t i_wb_addr,
  input  word_t     i_wb_data,
  output logic      o_halt_seen,
  exec_bus_if.decode_mp bus
);

  logic      supported;
  word_t     dec_inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rd_field;
  word_t     imm_i;
  word_t     imm_u;
  word_t     imm_b;
  alu_op_e   dec_alu_op;
  logic      dec_b_imm;
  word_t     dec_imm;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  logic      dec_rd_we;
  logic      dec_branch;
  logic      dec_ne;
  word_t     rs1_data;
  word_t     rs2_data;

  // funct3 picks the operation, alt picks sub over add and sra over srl
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000: op = alt ? ALU_SUB : ALU_ADD;
      3'b001: op = ALU_SLL;
      3'b010: op = ALU_SLT;
      3'b011: op = ALU_SLTU;
      3'b100: op = ALU_XOR;
      3'b101: op = alt ? ALU_SRA : ALU_SRL;
      3'b110: op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ebreak is seen while it sits in the fetch/decode register
  assign o_halt_seen = i_valid && (i_inst == EBREAK_INST);

  // screen the raw word, anything outside the supported set runs as a nop
  always_comb begin
    case (i_inst[6:0])
      OPC_OP: begin
        supported = (i_inst[31:25] == 7'b0000000) ||
                    ((i_inst[31:25] == 7'b0100000) &&
                     ((i_inst[14:12] == 3'b000) || (i_inst[14:12] == 3'b101)));
      end
      // slli needs funct7 zero, srli and srai allow bit 30 only
      OPC_OP_IMM: begin
        if (i_inst[14:12] == 3'b001) begin
          supported = (i_inst[31:25] == 7'b0000000);
        end else if (i_inst[14:12] == 3'b101) begin
          supported = ({i_inst[31], i_inst[29:25]} == 6'b000000);
        end else begin
          supported = 1'b1;
        end
      end
      OPC_LUI:    supported = 1'b1;
      OPC_BRANCH: supported = (i_inst[14:13] == 2'b00);
      default:    supported = 1'b0;
    endcase
  end

  // bubbles decode as the canonical nop as well
  assign dec_inst = (i_valid && supported) ? i_inst : NOP_INST;

  assign opcode   = dec_inst[6:0];
  assign funct3   = dec_inst[14:12];
  assign funct7   = dec_inst[31:25];
  assign rd_field = dec_inst[11:7];

  assign imm_i = {{20{dec_inst[31]}}, dec_inst[31:20]};
  assign imm_u = {dec_inst[31:12], 12'b0};
  assign imm_b = {{19{dec_inst[31]}}, dec_inst[31], dec_inst[7], dec_inst[30:25],
                  dec_inst[11:8], 1'b0};

  // unused source ports read x0, so retire reports them as index 0 with data 0
  always_comb begin
    dec_alu_op = ALU_ADD;
    dec_b_imm  = 1'b0;
    dec_imm    = imm_i;
    dec_rs1    = dec_inst[19:15];
    dec_rs2    = '0;
    dec_rd_we  = 1'b0;
    dec_branch = 1'b0;
    dec_ne     = 1'b0;
    case (opcode)
      OPC_OP: begin
        dec_alu_op = alu_from_funct(funct3, funct7[5]);
        dec_rs2    = dec_inst[24:20];
        dec_rd_we  = (rd_field != '0);
      end
      OPC_OP_IMM: begin
        // addi has no subtract form, so bit 30 only matters for shifts
        dec_alu_op = alu_from_funct(funct3, funct7[5] && (funct3 == 3'b101));
        dec_b_imm  = 1'b1;
        dec_rd_we  = (rd_field != '0);
      end
      OPC_LUI: begin
        dec_alu_op = ALU_PASS_B;
        dec_b_imm  = 1'b1;
        dec_imm    = imm_u;
        dec_rs1    = '0;
        dec_rd_we  = (rd_field != '0);
      end
      OPC_BRANCH: begin
        dec_imm    = imm_b;
        dec_rs2    = dec_inst[24:20];
        dec_branch = 1'b1;
        dec_ne     = funct3[0];
      end
      default: begin
        dec_rs1 = '0;
      end
    endcase
  end

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (dec_rs1),
    .i_rs2_addr (dec_rs2),
    .i_wb_we    (i_wb_we),
    .i_wb_addr  (i_wb_addr),
    .i_wb_data  (i_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // a taken branch in execute turns the younger instruction into a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst || i_redirect) begin
      bus.valid     <= 1'b0;
      bus.rd_we     <= 1'b0;
      bus.is_branch <= 1'b0;
    end else begin
      bus.valid     <= i_valid;
      bus.rd_we     <= dec_rd_we;
      bus.is_branch <= dec_branch;
    end
  end

  always_ff @(posedge i_clk) begin
    bus.pc               <= i_pc;
    bus.inst             <= i_inst;
    bus.alu_op           <= dec_alu_op;
    bus.operand_b_is_imm <= dec_b_imm;
    bus.imm              <= dec_imm;
    bus.rs1_addr         <= dec_rs1;
    bus.rs2_addr         <= dec_rs2;
    bus.rs1_data         <= rs1_data;
    bus.rs2_data         <= rs2_data;
    bus.rd_addr          <= rd_field;
    bus.branch_ne        <= dec_ne;
  end

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  exec_bus_if.execute_mp bus,
  output logic      o_redirect,
  output word_t     o_redirect_pc,
  output logic      o_wb_we,
  output reg_addr_t o_wb_addr,
  output word_t     o_wb_data,
  output logic      o_retire_valid,
  output word_t     o_retire_inst,
  output word_t     o_retire_pc,
  output word_t     o_retire_next_pc,
  output reg_addr_t o_retire_rs1_raddr,
  output reg_addr_t o_retire_rs2_raddr,
  output word_t     o_retire_rs1_rdata,
  output word_t     o_retire_rs2_rdata,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata,
  output logic      o_retire_halt
);

  word_t     op_a;
  word_t     op_b_reg;
  word_t     op_b;
  word_t     alu_result;
  logic      taken;
  word_t     target;
  word_t     next_pc;
  logic      xw_valid_q;
  logic      xw_we_q;
  logic      xw_halt_q;
  reg_addr_t xw_addr_q;
  word_t     xw_data_q;
  word_t     xw_inst_q;
  word_t     xw_pc_q;
  word_t     xw_next_pc_q;
  reg_addr_t xw_rs1_addr_q;
  reg_addr_t xw_rs2_addr_q;
  word_t     xw_rs1_data_q;
  word_t     xw_rs2_data_q;

  // the instruction just ahead has not reached the register file yet,
  // so its result replaces the stale operand read in decode
  assign op_a = (xw_we_q && (xw_addr_q != '0) && (xw_addr_q == bus.rs1_addr)) ?
                xw_data_q : bus.rs1_data;
  assign op_b_reg = (xw_we_q && (xw_addr_q != '0) && (xw_addr_q == bus.rs2_addr)) ?
                    xw_data_q : bus.rs2_data;
  assign op_b = bus.operand_b_is_imm ? bus.imm : op_b_reg;

  always_comb begin
    case (bus.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << op_b[4:0];
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // beq takes on equal operands, bne on unequal ones
  // decode clears is_branch on bubbles, so a flushed branch never redirects
  assign taken   = bus.is_branch && ((op_a == op_b_reg) != bus.branch_ne);
  assign target  = bus.pc + bus.imm;
  assign next_pc = taken ? target : bus.pc + 32'd4;

  assign o_redirect    = taken;
  assign o_redirect_pc = target;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      xw_valid_q <= 1'b0;
      xw_we_q    <= 1'b0;
      xw_halt_q  <= 1'b0;
    end else begin
      xw_valid_q <= bus.valid;
      xw_we_q    <= bus.rd_we;
      xw_halt_q  <= bus.valid && (bus.inst == EBREAK_INST);
    end
  end

  // the destination index is kept as 0 for instructions without a write
  always_ff @(posedge i_clk) begin
    xw_addr_q     <= bus.rd_we ? bus.rd_addr : '0;
    xw_data_q     <= alu_result;
    xw_inst_q     <= bus.inst;
    xw_pc_q       <= bus.pc;
    xw_next_pc_q  <= next_pc;
    xw_rs1_addr_q <= bus.rs1_addr;
    xw_rs2_addr_q <= bus.rs2_addr;
    xw_rs1_data_q <= op_a;
    xw_rs2_data_q <= op_b_reg;
  end

  // the same register feeds the register file write and the retire port
  assign o_wb_we   = xw_we_q;
  assign o_wb_addr = xw_addr_q;
  assign o_wb_data = xw_data_q;

  assign o_retire_valid     = xw_valid_q;
  assign o_retire_inst      = xw_inst_q;
  assign o_retire_pc        = xw_pc_q;
  assign o_retire_next_pc   = xw_next_pc_q;
  assign o_retire_rs1_raddr = xw_rs1_addr_q;
  assign o_retire_rs2_raddr = xw_rs2_addr_q;
  assign o_retire_rs1_rdata = xw_rs1_data_q;
  assign o_retire_rs2_rdata = xw_rs2_data_q;
  assign o_retire_rd_waddr  = xw_addr_q;
  assign o_retire_rd_wdata  = xw_data_q;
  assign o_retire_halt      = xw_halt_q;

endmodule

//--- rtl/hart.sv
`timescale 1ns/1ps

module hart import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  output logic      o_imem_cyc,
  output logic      o_imem_stb,
  output word_t     o_imem_adr,
  input  word_t     i_imem_dat,
  input  logic      i_imem_ack,
  output logic      o_retire_valid,
  output word_t     o_retire_inst,
  output word_t     o_retire_pc,
  output word_t     o_retire_next_pc,
  output reg_addr_t o_retire_rs1_raddr,
  output reg_addr_t o_retire_rs2_raddr,
  output word_t     o_retire_rs1_rdata,
  output word_t     o_retire_rs2_rdata,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata,
  output logic      o_retire_halt
);

  // fetch/decode register outputs
  logic      fd_valid;
  word_t     fd_pc;
  word_t     fd_inst;
  // branch redirect, decided in execute only
  logic      redirect;
  word_t     redirect_pc;
  logic      halt_seen;
  // register file write port, driven from the execute/writeback register
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  exec_bus_if x_bus ();

  fetch_unit u_fetch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_imem_dat    (i_imem_dat),
    .i_imem_ack    (i_imem_ack),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .i_halt_seen   (halt_seen),
    .o_imem_cyc    (o_imem_cyc),
    .o_imem_stb    (o_imem_stb),
    .o_imem_adr    (o_imem_adr),
    .o_valid       (fd_valid),
    .o_pc          (fd_pc),
    .o_inst        (fd_inst)
  );

  decode_unit u_decode (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (fd_valid),
    .i_pc        (fd_pc),
    .i_inst      (fd_inst),
    .i_redirect  (redirect),
    .i_wb_we     (wb_we),
    .i_wb_addr   (wb_addr),
    .i_wb_data   (wb_data),
    .o_halt_seen (halt_seen),
    .bus         (x_bus.decode_mp)
  );

  execute_unit u_execute (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .bus                (x_bus.execute_mp),
    .o_redirect         (redirect),
    .o_redirect_pc      (redirect_pc),
    .o_wb_we            (wb_we),
    .o_wb_addr          (wb_addr),
    .o_wb_data          (wb_data),
    .o_retire_valid     (o_retire_valid),
    .o_retire_inst      (o_retire_inst),
    .o_retire_pc        (o_retire_pc),
    .o_retire_next_pc   (o_retire_next_pc),
    .o_retire_rs1_raddr (o_retire_rs1_raddr),
    .o_retire_rs2_raddr (o_retire_rs2_raddr),
    .o_retire_rs1_rdata (o_retire_rs1_rdata),
    .o_retire_rs2_rdata (o_retire_rs2_rdata),
    .o_retire_rd_waddr  (o_retire_rd_waddr),
    .o_retire_rd_wdata  (o_retire_rd_wdata),
    .o_retire_halt      (o_retire_halt)
  );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

// free-running 20 ns clock and a reset that stays high for three rising edges
module tb_clock (
  input  logic i_rst_req,
  output logic o_clk,
  output logic o_rst
);

  logic       clk_q = 1'b0;
  // starts at three so that the DUT also sees a reset from time zero
  logic [1:0] rst_cnt = 2'd3;

  always #10 clk_q = ~clk_q;

  // a request reloads the counter, so reset covers the next three edges
  always @(posedge clk_q) begin
    if (i_rst_req) begin
      rst_cnt <= 2'd3;
    end else if (rst_cnt != 2'd0) begin
      rst_cnt <= rst_cnt - 2'd1;
    end
  end

  assign o_clk = clk_q;
  assign o_rst = (rst_cnt != 2'd0);

endmodule

//--- test/tb_hart.sv
`timescale 1ns/1ps

module tb_hart import hart_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      rst_req = 1'b0;
  word_t     imem_dat = '0;
  logic      imem_ack = 1'b0;
  logic      imem_cyc;
  logic      imem_stb;
  word_t     imem_adr;
  logic      r_valid;
  word_t     r_inst;
  word_t     r_pc;
  word_t     r_next_pc;
  reg_addr_t r_rs1_raddr;
  reg_addr_t r_rs2_raddr;
  word_t     r_rs1_rdata;
  word_t     r_rs2_rdata;
  reg_addr_t r_rd_waddr;
  word_t     r_rd_wdata;
  logic      r_halt;

  // instruction memory of 64 words seen through adr[7:2]
  word_t      imem [0:63];
  logic       wait_en = 1'b0;
  logic [1:0] wait_left = 2'd0;
  word_t      lfsr_q = 32'd77343;
  // reference model state that takes one architectural step per retirement
  word_t      mregs [0:31];
  word_t      mpc;
  word_t      prog [$];
  int         errors = 0;
  int         tests = 0;

  tb_clock u_clock (.i_rst_req(rst_req), .o_clk(clk), .o_rst(rst));

  hart uut (
    .i_clk (clk), .i_rst (rst),
    .o_imem_cyc (imem_cyc), .o_imem_stb (imem_stb), .o_imem_adr (imem_adr),
    .i_imem_dat (imem_dat), .i_imem_ack (imem_ack),
    .o_retire_valid (r_valid), .o_retire_inst (r_inst), .o_retire_pc (r_pc),
    .o_retire_next_pc (r_next_pc),
    .o_retire_rs1_raddr (r_rs1_raddr), .o_retire_rs2_raddr (r_rs2_raddr),
    .o_retire_rs1_rdata (r_rs1_rdata), .o_retire_rs2_rdata (r_rs2_rdata),
    .o_retire_rd_waddr (r_rd_waddr), .o_retire_rd_wdata (r_rd_wdata),
    .o_retire_halt (r_halt)
  );

  // Galois LFSR with taps 32, 22, 2 and 1
  function automatic word_t lfsr_next(input word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Wishbone classic slave whose registered ack makes one read take at least two edges
  always @(posedge clk) begin : slave
    word_t s1;
    word_t s2;
    if (rst) begin
      imem_ack  <= 1'b0;
      wait_left <= 2'd0;
    end else if (imem_ack) begin
      imem_ack <= 1'b0;
      // two LFSR steps give the wait states of the next read
      s1 = lfsr_next(lfsr_q);
      s2 = lfsr_next(s1);
      lfsr_q    <= s2;
      wait_left <= wait_en ? {s2[0], s1[0]} : 2'd0;
    end else if (imem_cyc && imem_stb) begin
      if (wait_left == 2'd0) begin
        imem_ack <= 1'b1;
        imem_dat <= imem[imem_adr[7:2]];
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout while waiting for %s", what);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("test %s: %s, %0d errors", name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  // unused words are addi x0 with the byte address as immediate
  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      if (i < prog.size()) begin
        imem[i] = prog[i];
      end else begin
        imem[i] = {i[9:0], 2'b00, 13'd0, OPC_OP_IMM};
      end
    end
  endtask

  task automatic emit_spaced(input word_t w);
    prog.push_back(w);
    prog.push_back(NOP_INST);
  endtask

  // returns at the first falling edge after reset has been released
  task automatic apply_reset();
    int guard;
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    // the DUT takes its first reset edge here
    @(posedge clk);
    @(negedge clk);
    guard = 0;
    while (rst) begin
      check_bit("cyc in reset", imem_cyc, 1'b0);
      check_bit("stb in reset", imem_stb, 1'b0);
      check_bit("retire valid in reset", r_valid, 1'b0);
      guard++;
      if (guard > 10) timeout_abort("reset release");
      @(negedge clk);
    end
  endtask

  // executes the instruction at mpc by the ISA rules and advances the model
  // sources that the instruction does not read are reported as x0
  task automatic model_step(output word_t inst, output word_t nxt, output reg_addr_t rd,
                            output word_t wd, output logic halt, output reg_addr_t rs1,
                            output reg_addr_t rs2, output word_t d1, output word_t d2);
    word_t      a;
    word_t      b;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       we;
    inst = imem[mpc[7:2]];
    opc  = inst[6:0];
    f3   = inst[14:12];
    rs1  = ((opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_BRANCH)) ?
           inst[19:15] : 5'd0;
    rs2  = ((opc == OPC_OP) || (opc == OPC_BRANCH)) ? inst[24:20] : 5'd0;
    d1   = mregs[rs1];
    d2   = mregs[rs2];
    a    = mregs[inst[19:15]];
    b    = (opc == OPC_OP) ? mregs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    nxt  = mpc + 32'd4;
    wd   = '0;
    we   = 1'b0;
    halt = (inst == EBREAK_INST);
    if (opc == OPC_LUI) begin
      we = 1'b1;
      wd = {inst[31:12], 12'b0};
    end else if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
      we = 1'b1;
      case (f3)
        3'd0: wd = ((opc == OPC_OP) && inst[30]) ? a - b : a + b;
        3'd1: wd = a << b[4:0];
        3'd2: wd = {31'b0, $signed(a) < $signed(b)};
        3'd3: wd = {31'b0, a < b};
        3'd4: wd = a ^ b;
        3'd5: begin
          if (inst[30]) wd = $signed(a) >>> b[4:0];
          else wd = a >> b[4:0];
        end
        3'd6: wd = a | b;
        default: wd = a & b;
      endcase
    end else if (opc == OPC_BRANCH) begin
      b = mregs[inst[24:20]];
      if ((a == b) != f3[0]) begin
        nxt = mpc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
    end
    rd = (we && (inst[11:7] != 5'd0)) ? inst[11:7] : 5'd0;
    if (rd != 5'd0) mregs[rd] = wd;
    mpc = nxt;
  endtask

  // runs prog until ebreak retires and checks every retirement against the model
  task automatic run_program(input logic waits);
    word_t     pc_e;
    word_t     inst_e;
    word_t     next_e;
    word_t     wd_e;
    reg_addr_t rd_e;
    logic      halt_e;
    reg_addr_t rs1_e;
    reg_addr_t rs2_e;
    word_t     d1_e;
    word_t     d2_e;
    int        guard;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    mpc     = RESET_ADDR;
    wait_en = waits;
    load_program();
    apply_reset();
    halt_e = 1'b0;
    while (!halt_e) begin
      guard = 0;
      @(negedge clk);
      while (!r_valid) begin
        guard++;
        if (guard > 200) timeout_abort("a retirement");
        @(negedge clk);
      end
      pc_e = mpc;
      model_step(inst_e, next_e, rd_e, wd_e, halt_e, rs1_e, rs2_e, d1_e, d2_e);
      check_word("retire pc", r_pc, pc_e);
      check_word("retire inst", r_inst, inst_e);
      check_word("retire next_pc", r_next_pc, next_e);
      check_reg("retire rs1_raddr", r_rs1_raddr, rs1_e);
      check_reg("retire rs2_raddr", r_rs2_raddr, rs2_e);
      check_word("retire rs1_rdata", r_rs1_rdata, d1_e);
      check_word("retire rs2_rdata", r_rs2_rdata, d2_e);
      check_reg("retire rd_waddr", r_rd_waddr, rd_e);
      if (rd_e != 5'd0) check_word("retire rd_wdata", r_rd_wdata, wd_e);
      check_bit("retire halt", r_halt, halt_e);
    end
    // after a halt nothing retires and the bus stays idle
    repeat (16) begin
      @(negedge clk);
      check_bit("retire valid after halt", r_valid, 1'b0);
      check_bit("cyc after halt", imem_cyc, 1'b0);
      check_bit("stb after halt", imem_stb, 1'b0);
    end
  endtask

  task automatic build_alu();
    prog = {};
    emit_spaced({20'h8001f, 5'd1, OPC_LUI});
    emit_spaced(enc_i(12'hff9, 5'd0, 3'd0, 5'd2));
    emit_spaced(enc_i(12'h005, 5'd0, 3'd0, 5'd3));
    for (int f = 0; f < 8; f++) emit_spaced(enc_r(7'h00, 5'd3, 5'd1, 3'(f), 5'(4 + f)));
    emit_spaced(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd12));
    emit_spaced(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd13));
    // shift immediates carry a shamt and the others a negative constant
    for (int f = 0; f < 8; f++) begin
      emit_spaced(enc_i(((f == 1) || (f == 5)) ? 12'h003 : 12'hf35, 5'd2, 3'(f), 5'(14 + f)));
    end
    emit_spaced(enc_i(12'h404, 5'd1, 3'd5, 5'd22));
    prog.push_back(EBREAK_INST);
  endtask

  // each instruction reads the previous result and the one before it
  task automatic build_deps();
    prog = {enc_i(12'h005, 5'd0, 3'd0, 5'd1), enc_i(12'h003, 5'd1, 3'd0, 5'd2),
            enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3), enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4),
            enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5), enc_r(7'h00, 5'd4, 5'd5, 3'd0, 5'd0),
            enc_r(7'h00, 5'd5, 5'd0, 3'd0, 5'd6), enc_r(7'h00, 5'd0, 5'd6, 3'd6, 5'd7),
            enc_i(12'hfff, 5'd7, 3'd3, 5'd8), enc_r(7'h00, 5'd8, 5'd7, 3'd1, 5'd9),
            EBREAK_INST};
  endtask

  // the branch at 48 skips an ebreak, which must not halt the hart
  task automatic build_branches();
    prog = {enc_i(12'h003, 5'd0, 3'd0, 5'd1), enc_i(12'h003, 5'd0, 3'd0, 5'd2),
            enc_b(13'd12, 5'd2, 5'd1, 3'd0), enc_i(12'h001, 5'd0, 3'd0, 5'd3),
            enc_i(12'h001, 5'd0, 3'd0, 5'd4), enc_b(13'd8, 5'd2, 5'd1, 3'd1),
            enc_i(12'h007, 5'd0, 3'd0, 5'd5), enc_b(13'd12, 5'd1, 5'd5, 3'd1),
            enc_i(12'h001, 5'd0, 3'd0, 5'd6), enc_i(12'h001, 5'd0, 3'd0, 5'd7),
            enc_b(13'd8, 5'd1, 5'd5, 3'd0), enc_i(12'h009, 5'd0, 3'd0, 5'd8),
            enc_b(13'd8, 5'd0, 5'd0, 3'd0), EBREAK_INST,
            enc_i(12'h001, 5'd8, 3'd0, 5'd9), EBREAK_INST};
  endtask

  task automatic test_reset();
    int e0;
    int guard;
    e0 = errors;
    build_deps();
    load_program();
    apply_reset();
    check_bit("cyc after reset", imem_cyc, 1'b0);
    check_bit("stb after reset", imem_stb, 1'b0);
    check_bit("retire valid after reset", r_valid, 1'b0);
    guard = 0;
    while (!imem_cyc) begin
      guard++;
      if (guard > 10) timeout_abort("the first fetch");
      @(negedge clk);
    end
    check_bit("stb with the first cyc", imem_stb, 1'b1);
    check_word("first fetch address", imem_adr, RESET_ADDR);
    report_test("reset", e0);
  endtask

  task automatic test_program(input string name, input int which);
    int e0;
    e0 = errors;
    if (which == 0) build_alu();
    else if (which == 1) build_deps();
    else build_branches();
    run_program(1'b0);
    report_test(name, e0);
  endtask

  // the retired sequence must not depend on fetch latency
  task automatic test_wait_states();
    int e0;
    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      if (k == 0) build_alu();
      else if (k == 1) build_deps();
      else build_branches();
      run_program(1'b1);
    end
    report_test("wait states", e0);
  endtask

  task automatic test_ebreak();
    int e0;
    e0 = errors;
    prog = {enc_i(12'h001, 5'd0, 3'd0, 5'd1), EBREAK_INST,
            enc_i(12'h002, 5'd0, 3'd0, 5'd2), enc_i(12'h003, 5'd0, 3'd0, 5'd3)};
    run_program(1'b0);
    report_test("ebreak", e0);
  endtask

  initial begin
    test_reset();
    test_program("alu", 0);
    test_program("dependencies", 1);
    test_program("branches", 2);
    test_wait_states();
    test_ebreak();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- hart.f
rtl/hart_pkg.sv
rtl/exec_bus_if.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/hart.sv
test/tb_clock.sv
test/tb_hart.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --top-module tb_hart -f hart.f -o sim_hart > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_hart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
